//--- include/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Datapath and table geometry
`define BP_XLEN          32
`define BP_INDEX_WIDTH   6
`define BP_HIST_WIDTH    6
`define BP_TAG_WIDTH     (`BP_XLEN - `BP_INDEX_WIDTH - 2)
`define BP_ENTRIES       (1 << `BP_INDEX_WIDTH)

// Two-bit agree counters
`define BP_CTR_WIDTH     2
`define BP_CTR_INIT      2
`define BP_CTR_MAX       3
`define BP_CTR_AGREE     2

// Wishbone register block
`define BP_WB_ADR_WIDTH  4
`define BP_WB_DATA_WIDTH 32
`define BP_CSR_CTRL      'h0
`define BP_CSR_BRANCHES  'h4
`define BP_CSR_REDIRECTS 'h8
`define BP_CTRL_ENABLE   0
`define BP_CTRL_CLEAR    1

`endif

//--- hw/bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

    typedef logic [`BP_XLEN-1:0]          addr_t;
    typedef logic [`BP_INDEX_WIDTH-1:0]   bp_index_t;
    typedef logic [`BP_TAG_WIDTH-1:0]     bp_tag_t;
    typedef logic [`BP_HIST_WIDTH-1:0]    ghr_t;
    typedef logic [`BP_CTR_WIDTH-1:0]     ctr_t;
    typedef logic [`BP_WB_ADR_WIDTH-1:0]  wb_adr_t;
    typedef logic [`BP_WB_DATA_WIDTH-1:0] wb_data_t;

    // Carried down the pipeline with each fetched instruction
    typedef struct packed {
        ghr_t  ghr;
        logic  hit;
        logic  bias;
        logic  taken;
        addr_t next_pc;
    } pred_meta_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } fetch_t;

    typedef struct packed {
        addr_t      next_pc;
        logic       taken;
        pred_meta_t meta;
    } pred_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        logic       is_cond;
        logic       is_jump;
        logic       taken;
        addr_t      target;
        pred_meta_t meta;
    } resolve_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Word-aligned PC, index sits just above the byte offset
    function automatic bp_index_t pc_index(addr_t pc);
        return pc[`BP_INDEX_WIDTH+1:2];
    endfunction

    function automatic bp_tag_t pc_tag(addr_t pc);
        return pc[`BP_XLEN-1:`BP_INDEX_WIDTH+2];
    endfunction

endpackage

//--- hw/bp_btb.sv
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_btb (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          clear_i,
    input  bp_pkg::addr_t rd_pc_i,
    input  logic          wr_en_i,
    input  bp_pkg::addr_t wr_pc_i,
    input  bp_pkg::addr_t wr_target_i,
    input  logic          wr_jump_i,
    output logic          hit_o,
    output logic          bias_o,
    output logic          jump_o,
    output bp_pkg::addr_t target_o
);
    import bp_pkg::*;

    logic [`BP_ENTRIES-1:0] valid_q;
    bp_tag_t                tag_q    [`BP_ENTRIES];
    addr_t                  target_q [`BP_ENTRIES];
    logic                   bias_q   [`BP_ENTRIES];
    logic                   jump_q   [`BP_ENTRIES];

    bp_index_t rd_idx;
    bp_index_t wr_idx;
    logic      wr_hit;

    assign rd_idx = pc_index(rd_pc_i);
    assign wr_idx = pc_index(wr_pc_i);

    // Fetch-side lookup
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == pc_tag(rd_pc_i));
    assign bias_o   = bias_q[rd_idx];
    assign jump_o   = jump_q[rd_idx];
    assign target_o = target_q[rd_idx];

    // Same entry already owned by the resolving branch?
    assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == pc_tag(wr_pc_i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (clear_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entries are only written on a taken outcome,
    // so a freshly allocated entry starts biased taken
    always_ff @(posedge clk_i) begin
        if (wr_en_i && !clear_i) begin
            tag_q[wr_idx]    <= pc_tag(wr_pc_i);
            target_q[wr_idx] <= wr_target_i;
            jump_q[wr_idx]   <= wr_jump_i;
            if (!wr_hit) begin
                bias_q[wr_idx] <= 1'b1;
            end
        end
    end

    // Clear comes from the CSR block, writes from the resolve port
    ap_no_write_on_clear: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(wr_en_i && clear_i)
    ) else $error("BTB write during table clear");

endmodule

//--- hw/bp_pht.sv
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_pht (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          clear_i,
    input  bp_pkg::addr_t rd_pc_i,
    input  logic          upd_en_i,
    input  bp_pkg::addr_t upd_pc_i,
    input  bp_pkg::ghr_t  upd_ghr_i,
    input  logic          upd_agree_i,
    input  logic          hist_en_i,
    input  logic          hist_taken_i,
    output bp_pkg::ctr_t  ctr_o,
    output bp_pkg::ghr_t  ghr_o
);
    import bp_pkg::*;

    ctr_t      pht_q [`BP_ENTRIES];
    ghr_t      ghr_q;
    bp_index_t rd_idx;
    bp_index_t upd_idx;
    ctr_t      upd_old;
    ctr_t      upd_new;

    // Gshare-style hashing of PC and history
    assign rd_idx  = pc_index(rd_pc_i) ^ bp_index_t'(ghr_q);
    assign upd_idx = pc_index(upd_pc_i) ^ bp_index_t'(upd_ghr_i);

    assign ctr_o   = pht_q[rd_idx];
    assign ghr_o   = ghr_q;
    assign upd_old = pht_q[upd_idx];

    // Saturating step toward agree or disagree
    always_comb begin
        upd_new = upd_old;
        if (upd_agree_i) begin
            if (upd_old != ctr_t'(`BP_CTR_MAX)) begin
                upd_new = upd_old + ctr_t'(1);
            end
        end else if (upd_old != '0) begin
            upd_new = upd_old - ctr_t'(1);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                pht_q[i] <= ctr_t'(`BP_CTR_INIT);
            end
            ghr_q <= '0;
        end else if (clear_i) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                pht_q[i] <= ctr_t'(`BP_CTR_INIT);
            end
            ghr_q <= '0;
        end else begin
            if (upd_en_i) begin
                pht_q[upd_idx] <= upd_new;
            end
            // Newest outcome enters at bit 0
            if (hist_en_i) begin
                ghr_q <= {ghr_q[`BP_HIST_WIDTH-2:0], hist_taken_i};
            end
        end
    end

    // An updated counter never wraps around its range
    ap_ctr_no_wrap: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        upd_en_i && !clear_i |=>
            !($past(upd_old) == ctr_t'(`BP_CTR_MAX) && pht_q[$past(upd_idx)] == '0) &&
            !($past(upd_old) == '0 && pht_q[$past(upd_idx)] == ctr_t'(`BP_CTR_MAX))
    ) else $error("Agree counter left its range");

endmodule

//--- hw/bp_next_pc.sv
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_next_pc (
    input  bp_pkg::fetch_t    fetch_i,
    input  logic              enable_i,
    input  logic              btb_hit_i,
    input  logic              btb_bias_i,
    input  logic              btb_jump_i,
    input  bp_pkg::addr_t     btb_target_i,
    input  bp_pkg::ctr_t      ctr_i,
    input  bp_pkg::ghr_t      ghr_i,
    input  bp_pkg::resolve_t  resolve_i,
    output bp_pkg::pred_t     pred_o,
    output bp_pkg::redirect_t redirect_o,
    output logic              btb_wr_o,
    output logic              pht_upd_o,
    output logic              pht_agree_o,
    output logic              hist_en_o
);
    import bp_pkg::*;

    logic  pred_hit;
    logic  ctr_agree;
    logic  pred_taken;
    addr_t fetch_plus4;
    addr_t pred_next;
    logic  res_active;
    addr_t res_actual;

    // Fetch side
    assign pred_hit    = fetch_i.valid && enable_i && btb_hit_i;
    assign ctr_agree   = ctr_i >= ctr_t'(`BP_CTR_AGREE);
    assign pred_taken  = pred_hit && (btb_jump_i || (btb_bias_i == ctr_agree));
    assign fetch_plus4 = fetch_i.pc + addr_t'(4);
    assign pred_next   = pred_taken ? btb_target_i : fetch_plus4;

    assign pred_o.next_pc      = pred_next;
    assign pred_o.taken        = pred_taken;
    assign pred_o.meta.ghr     = ghr_i;
    assign pred_o.meta.hit     = pred_hit;
    assign pred_o.meta.bias    = pred_hit && btb_bias_i;
    assign pred_o.meta.taken   = pred_taken;
    assign pred_o.meta.next_pc = pred_next;

    // Resolve side
    assign res_active = resolve_i.valid && (resolve_i.is_cond || resolve_i.is_jump);
    assign res_actual = resolve_i.taken ? resolve_i.target : resolve_i.pc + addr_t'(4);

    assign redirect_o.valid = res_active && (res_actual != resolve_i.meta.next_pc);
    assign redirect_o.pc    = res_actual;

    // Table update strobes
    assign btb_wr_o    = res_active && resolve_i.taken;
    assign pht_upd_o   = resolve_i.valid && resolve_i.is_cond && resolve_i.meta.hit;
    assign pht_agree_o = resolve_i.taken == resolve_i.meta.bias;
    assign hist_en_o   = resolve_i.valid && resolve_i.is_cond;

    // A resolved instruction is either a conditional branch or a jump
    always_comb begin
        if (resolve_i.valid) begin
            assert (!(resolve_i.is_cond && resolve_i.is_jump))
                else $error("Resolution marked both conditional and jump");
        end
    end

endmodule

//--- hw/bp_csr.sv
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_csr (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  bp_pkg::wb_req_t wb_i,
    input  logic            branch_i,
    input  logic            redirect_i,
    output bp_pkg::wb_rsp_t wb_o,
    output logic            enable_o,
    output logic            clear_o
);
    import bp_pkg::*;

    logic     ack_q;
    logic     enable_q;
    wb_data_t branches_q;
    wb_data_t redirects_q;
    logic     wr_fire;
    logic     is_ctrl;
    logic     is_stat;
    logic     stat_zero;
    wb_data_t rd_data;

    assign is_ctrl = wb_i.adr == wb_adr_t'(`BP_CSR_CTRL);
    assign is_stat = (wb_i.adr == wb_adr_t'(`BP_CSR_BRANCHES)) ||
                     (wb_i.adr == wb_adr_t'(`BP_CSR_REDIRECTS));

    // Master holds the request, so the write lands on the ack edge
    assign wr_fire   = ack_q && wb_i.we;
    assign clear_o   = wr_fire && is_ctrl && wb_i.dat[`BP_CTRL_CLEAR];
    assign stat_zero = wr_fire && is_stat;

    // Single-cycle ack, dropped before the next request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_i.cyc && wb_i.stb && !ack_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b1;
        end else if (wr_fire && is_ctrl) begin
            enable_q <= wb_i.dat[`BP_CTRL_ENABLE];
        end
    end

    // Statistics, a write to either address zeroes both
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            branches_q  <= '0;
            redirects_q <= '0;
        end else if (stat_zero) begin
            branches_q  <= '0;
            redirects_q <= '0;
        end else begin
            if (branch_i) begin
                branches_q <= branches_q + wb_data_t'(1);
            end
            if (redirect_i) begin
                redirects_q <= redirects_q + wb_data_t'(1);
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_i.adr)
            wb_adr_t'(`BP_CSR_CTRL):      rd_data[`BP_CTRL_ENABLE] = enable_q;
            wb_adr_t'(`BP_CSR_BRANCHES):  rd_data = branches_q;
            wb_adr_t'(`BP_CSR_REDIRECTS): rd_data = redirects_q;
            default:                      rd_data = '0;
        endcase
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rd_data;
    assign enable_o = enable_q;

    // Master must keep the cycle open until the ack
    ap_ack_with_stb: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_o.ack |-> wb_i.cyc && wb_i.stb
    ) else $error("Wishbone ack without an active strobe");

endmodule

//--- hw/bp_top.sv
`timescale 1ns/1ps

module bp_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  bp_pkg::fetch_t    fetch_i,
    input  bp_pkg::resolve_t  resolve_i,
    input  bp_pkg::wb_req_t   wb_i,
    output bp_pkg::pred_t     pred_o,
    output bp_pkg::redirect_t redirect_o,
    output bp_pkg::wb_rsp_t   wb_o
);
    import bp_pkg::*;

    logic  enable;
    logic  clear;
    logic  btb_hit;
    logic  btb_bias;
    logic  btb_jump;
    addr_t btb_target;
    ctr_t  pht_ctr;
    ghr_t  ghr;
    logic  btb_wr;
    logic  pht_upd;
    logic  pht_agree;
    logic  hist_en;

    bp_btb u_btb (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear),
        .rd_pc_i     (fetch_i.pc),
        .wr_en_i     (btb_wr),
        .wr_pc_i     (resolve_i.pc),
        .wr_target_i (resolve_i.target),
        .wr_jump_i   (resolve_i.is_jump),
        .hit_o       (btb_hit),
        .bias_o      (btb_bias),
        .jump_o      (btb_jump),
        .target_o    (btb_target)
    );

    bp_pht u_pht (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear),
        .rd_pc_i      (fetch_i.pc),
        .upd_en_i     (pht_upd),
        .upd_pc_i     (resolve_i.pc),
        .upd_ghr_i    (resolve_i.meta.ghr),
        .upd_agree_i  (pht_agree),
        .hist_en_i    (hist_en),
        .hist_taken_i (resolve_i.taken),
        .ctr_o        (pht_ctr),
        .ghr_o        (ghr)
    );

    bp_next_pc u_next_pc (
        .fetch_i      (fetch_i),
        .enable_i     (enable),
        .btb_hit_i    (btb_hit),
        .btb_bias_i   (btb_bias),
        .btb_jump_i   (btb_jump),
        .btb_target_i (btb_target),
        .ctr_i        (pht_ctr),
        .ghr_i        (ghr),
        .resolve_i    (resolve_i),
        .pred_o       (pred_o),
        .redirect_o   (redirect_o),
        .btb_wr_o     (btb_wr),
        .pht_upd_o    (pht_upd),
        .pht_agree_o  (pht_agree),
        .hist_en_o    (hist_en)
    );

    // Each valid resolution is one branch or jump
    bp_csr u_csr (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wb_i       (wb_i),
        .branch_i   (resolve_i.valid),
        .redirect_i (redirect_o.valid),
        .wb_o       (wb_o),
        .enable_o   (enable),
        .clear_o    (clear)
    );

endmodule

//--- bench/bp_tb.sv
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_tb;
    import bp_pkg::*;

    localparam int ack_timeout     = 20;
    localparam int train_limit     = 20;
    localparam int pool_size       = 12;
    localparam int num_resolutions = 300;

    localparam addr_t br_pc        = 32'h0000_1040;
    localparam addr_t br_target    = 32'h0000_2000;
    localparam addr_t jmp_pc       = 32'h0000_3100;
    localparam addr_t jmp_target_a = 32'h0000_4000;
    localparam addr_t jmp_target_b = 32'h0000_5000;

    typedef struct packed {
        pred_t     pred;
        redirect_t redirect;
    } expect_t;

    logic      clk;
    logic      rst_n;
    fetch_t    fetch;
    resolve_t  resolve;
    wb_req_t   wb_req;
    pred_t     pred;
    redirect_t redirect;
    wb_rsp_t   wb_rsp;
    integer    seed;
    int        error_count;

    // Reference copy of the predictor and CSR state
    logic     m_valid  [`BP_ENTRIES];
    bp_tag_t  m_tag    [`BP_ENTRIES];
    addr_t    m_target [`BP_ENTRIES];
    logic     m_bias   [`BP_ENTRIES];
    logic     m_jump   [`BP_ENTRIES];
    ctr_t     m_pht    [`BP_ENTRIES];
    ghr_t     m_ghr;
    logic     m_enable;
    logic     m_ack;
    wb_data_t m_branches;
    wb_data_t m_redirects;

    // Branches used by the random mix
    addr_t pool_pc     [pool_size];
    addr_t pool_target [pool_size];
    logic  pool_jump   [pool_size];

    bp_top u_bp_top (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .fetch_i    (fetch),
        .resolve_i  (resolve),
        .wb_i       (wb_req),
        .pred_o     (pred),
        .redirect_o (redirect),
        .wb_o       (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            error_count++;
            fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic model_clear();
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_bias[i]   = 1'b0;
            m_jump[i]   = 1'b0;
            m_pht[i]    = ctr_t'(`BP_CTR_INIT);
        end
        m_ghr = '0;
    endtask

    task automatic model_reset();
        model_clear();
        m_enable    = 1'b1;
        m_ack       = 1'b0;
        m_branches  = '0;
        m_redirects = '0;
    endtask

    // Expected prediction and redirect for the current inputs
    function automatic expect_t bp_model(fetch_t f, resolve_t r);
        bp_index_t idx;
        logic      hit;
        logic      agree;
        logic      taken;
        addr_t     actual;
        expect_t   e;
        idx   = f.pc[`BP_INDEX_WIDTH+1:2];
        hit   = f.valid && m_enable && m_valid[idx] &&
                (m_tag[idx] == f.pc[`BP_XLEN-1:`BP_INDEX_WIDTH+2]);
        // Agree means counter at least 2
        agree = m_pht[idx ^ m_ghr] >= ctr_t'(2);
        taken = hit && (m_jump[idx] || (m_bias[idx] == agree));
        e.pred.next_pc      = taken ? m_target[idx] : f.pc + 32'd4;
        e.pred.taken        = taken;
        e.pred.meta.ghr     = m_ghr;
        e.pred.meta.hit     = hit;
        e.pred.meta.bias    = hit && m_bias[idx];
        e.pred.meta.taken   = taken;
        e.pred.meta.next_pc = e.pred.next_pc;
        actual = r.taken ? r.target : r.pc + 32'd4;
        e.redirect.valid = r.valid && (r.is_cond || r.is_jump) && (actual != r.meta.next_pc);
        e.redirect.pc    = actual;
        return e;
    endfunction

    // State after the coming edge
    task automatic model_step(input logic redir);
        bp_index_t idx;
        bp_index_t uidx;
        logic      same;
        logic      fire;
        logic      is_ctrl;
        logic      next_ack;
        fire     = m_ack && wb_req.we;
        is_ctrl  = wb_req.adr == wb_adr_t'(`BP_CSR_CTRL);
        next_ack = wb_req.cyc && wb_req.stb && !m_ack;
        idx      = resolve.pc[`BP_INDEX_WIDTH+1:2];
        uidx     = idx ^ resolve.meta.ghr;
        if (fire && is_ctrl) begin
            m_enable = wb_req.dat[0];
        end
        if (fire && is_ctrl && wb_req.dat[1]) begin
            model_clear();
        end else if (resolve.valid) begin
            if ((resolve.is_cond || resolve.is_jump) && resolve.taken) begin
                same = m_valid[idx] && (m_tag[idx] == resolve.pc[`BP_XLEN-1:`BP_INDEX_WIDTH+2]);
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = resolve.pc[`BP_XLEN-1:`BP_INDEX_WIDTH+2];
                m_target[idx] = resolve.target;
                m_jump[idx]   = resolve.is_jump;
                if (!same) begin
                    m_bias[idx] = 1'b1;
                end
            end
            if (resolve.is_cond && resolve.meta.hit) begin
                if (resolve.taken == resolve.meta.bias) begin
                    if (m_pht[uidx] != ctr_t'(`BP_CTR_MAX)) begin
                        m_pht[uidx] = m_pht[uidx] + ctr_t'(1);
                    end
                end else if (m_pht[uidx] != '0) begin
                    m_pht[uidx] = m_pht[uidx] - ctr_t'(1);
                end
            end
            if (resolve.is_cond) begin
                m_ghr = {m_ghr[`BP_HIST_WIDTH-2:0], resolve.taken};
            end
        end
        if (fire && (wb_req.adr == wb_adr_t'(`BP_CSR_BRANCHES) ||
                     wb_req.adr == wb_adr_t'(`BP_CSR_REDIRECTS))) begin
            m_branches  = '0;
            m_redirects = '0;
        end else begin
            if (resolve.valid) begin
                m_branches = m_branches + 32'd1;
            end
            if (redir) begin
                m_redirects = m_redirects + 32'd1;
            end
        end
        m_ack = next_ack;
    endtask

    always @(posedge clk) begin : compare_outputs
        expect_t e;
        #1;
        if (!rst_n) begin
            model_reset();
        end else begin
            e = bp_model(fetch, resolve);
            check_value("pred_o.next_pc", 64'(pred.next_pc), 64'(e.pred.next_pc));
            check_value("pred_o.taken", 64'(pred.taken), 64'(e.pred.taken));
            check_value("pred_o.meta", 64'(pred.meta), 64'(e.pred.meta));
            check_value("redirect_o.valid", 64'(redirect.valid), 64'(e.redirect.valid));
            if (e.redirect.valid) begin
                check_value("redirect_o.pc", 64'(redirect.pc), 64'(e.redirect.pc));
            end
            check_value("wb_o.ack", 64'(wb_rsp.ack), 64'(m_ack));
            model_step(e.redirect.valid);
        end
    end

    task automatic run_cycle(input addr_t pc, input resolve_t r,
                             output pred_t p, output redirect_t rd);
        fetch_t f;
        f.valid = 1'b1;
        f.pc    = pc;
        @(posedge clk);
        fetch   <= f;
        resolve <= r;
        #2;
        p  = pred;
        rd = redirect;
    endtask

    function automatic resolve_t make_resolve(addr_t pc, logic is_jump, logic taken,
                                              addr_t target, pred_meta_t meta);
        resolve_t r;
        r.valid   = 1'b1;
        r.pc      = pc;
        r.is_cond = !is_jump;
        r.is_jump = is_jump;
        r.taken   = taken;
        r.target  = target;
        r.meta    = meta;
        return r;
    endfunction

    // Fetch, then resolve one cycle later while fetching the same PC again
    task automatic exec_branch(input addr_t pc, input logic is_jump, input logic taken,
                               input addr_t target, output pred_t p, output redirect_t rd);
        pred_t     again;
        redirect_t none;
        run_cycle(pc, '0, p, none);
        run_cycle(pc, make_resolve(pc, is_jump, taken, target, p.meta), again, rd);
        // Refetch still sees the tables from before the update
        check_value("pred_o.next_pc", 64'(again.next_pc), 64'(p.next_pc));
        check_value("pred_o.meta", 64'(again.meta), 64'(p.meta));
    endtask

    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        wb_req_t req;
        int      waited;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdata;
        @(posedge clk);
        resolve <= '0;
        wb_req  <= req;
        waited = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wb_rsp.ack && waited < ack_timeout);
        if (!wb_rsp.ack) begin
            fail_run($sformatf("No Wishbone ack after %0d cycles at address 0x%0h",
                               ack_timeout, adr));
        end
        rdata = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic csr_read(input wb_adr_t adr, output wb_data_t data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic csr_write(input wb_adr_t adr, input wb_data_t data);
        wb_data_t unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    initial begin : stimulus
        pred_t       p;
        redirect_t   rd;
        wb_data_t    rdata;
        resolve_t    r;
        addr_t       fpc;
        pred_meta_t  prev_meta;
        logic [31:0] rnd;
        logic        t;
        logic        prev_valid;
        int          k;
        int          prev_k;
        int          iter;
        seed        = 32'h5077ae8d;
        error_count = 0;
        rst_n       = 1'b0;
        fetch       = '0;
        resolve     = '0;
        wb_req      = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Empty tables fall through
        for (int n = 0; n < 4; n++) begin
            fpc = rand_word() & 32'hffff_fffc;
            run_cycle(fpc, '0, p, rd);
            check_value("pred_o.taken", 64'(p.taken), 64'd0);
            check_value("pred_o.next_pc", 64'(p.next_pc), 64'(fpc + 32'd4));
            check_value("redirect_o.valid", 64'(rd.valid), 64'd0);
        end
        csr_read(wb_adr_t'(`BP_CSR_CTRL), rdata);
        check_value("wb_o.dat CTRL", 64'(rdata), 64'd1);
        csr_read(wb_adr_t'(`BP_CSR_BRANCHES), rdata);
        check_value("wb_o.dat BRANCHES", 64'(rdata), 64'd0);
        csr_read(wb_adr_t'(`BP_CSR_REDIRECTS), rdata);
        check_value("wb_o.dat REDIRECTS", 64'(rdata), 64'd0);

        // First taken branch allocates, then hits
        exec_branch(br_pc, 1'b0, 1'b1, br_target, p, rd);
        check_value("redirect_o.valid", 64'(rd.valid), 64'd1);
        check_value("redirect_o.pc", 64'(rd.pc), 64'(br_target));
        run_cycle(br_pc, '0, p, rd);
        check_value("pred_o.taken", 64'(p.taken), 64'd1);
        check_value("pred_o.next_pc", 64'(p.next_pc), 64'(br_target));

        // Not-taken outcomes walk the history until the counter disagrees
        iter = 0;
        do begin
            exec_branch(br_pc, 1'b0, 1'b0, br_target, p, rd);
            check_value("redirect_o.valid", 64'(rd.valid), 64'(p.taken));
            iter++;
        end while (p.taken && iter < train_limit);
        if (p.taken) begin
            fail_run("Branch still predicted taken after repeated not-taken outcomes");
        end

        // Jump allocation and retargeting
        exec_branch(jmp_pc, 1'b1, 1'b1, jmp_target_a, p, rd);
        check_value("redirect_o.pc", 64'(rd.pc), 64'(jmp_target_a));
        run_cycle(jmp_pc, '0, p, rd);
        check_value("pred_o.next_pc", 64'(p.next_pc), 64'(jmp_target_a));
        exec_branch(jmp_pc, 1'b1, 1'b1, jmp_target_b, p, rd);
        check_value("pred_o.next_pc", 64'(p.next_pc), 64'(jmp_target_a));
        check_value("redirect_o.valid", 64'(rd.valid), 64'd1);
        check_value("redirect_o.pc", 64'(rd.pc), 64'(jmp_target_b));
        run_cycle(jmp_pc, '0, p, rd);
        check_value("pred_o.next_pc", 64'(p.next_pc), 64'(jmp_target_b));

        // Random mix, each fetch resolved in the following cycle
        for (int n = 0; n < pool_size; n++) begin
            pool_pc[n]     = 32'h0001_0000 | (rand_word() & 32'h0000_0ffc);
            pool_target[n] = 32'h0002_0000 | (rand_word() & 32'h0000_fffc);
            pool_jump[n]   = (n % 4) == 0;
        end
        prev_valid = 1'b0;
        prev_k     = 0;
        prev_meta  = '0;
        for (int n = 0; n <= num_resolutions; n++) begin
            k = rand_word() % pool_size;
            r = '0;
            if (prev_valid) begin
                rnd = rand_word();
                t   = pool_jump[prev_k] ? 1'b1 : (rnd[1:0] != 2'd0);
                if (pool_jump[prev_k] && rnd[4:2] == 3'd0) begin
                    pool_target[prev_k] = 32'h0002_0000 | (rand_word() & 32'h0000_fffc);
                end
                r = make_resolve(pool_pc[prev_k], pool_jump[prev_k], t,
                                 pool_target[prev_k], prev_meta);
            end
            run_cycle(pool_pc[k], r, p, rd);
            prev_k     = k;
            prev_meta  = p.meta;
            prev_valid = 1'b1;
        end
        csr_read(wb_adr_t'(`BP_CSR_BRANCHES), rdata);
        check_value("wb_o.dat BRANCHES", 64'(rdata), 64'(m_branches));
        csr_read(wb_adr_t'(`BP_CSR_REDIRECTS), rdata);
        check_value("wb_o.dat REDIRECTS", 64'(rdata), 64'(m_redirects));

        // Enable off, then table clear and statistics reset
        exec_branch(jmp_pc, 1'b1, 1'b1, jmp_target_a, p, rd);
        run_cycle(jmp_pc, '0, p, rd);
        check_value("pred_o.meta.hit", 64'(p.meta.hit), 64'd1);
        csr_write(wb_adr_t'(`BP_CSR_CTRL), 32'h0);
        run_cycle(jmp_pc, '0, p, rd);
        check_value("pred_o.taken", 64'(p.taken), 64'd0);
        check_value("pred_o.next_pc", 64'(p.next_pc), 64'(jmp_pc + 32'd4));
        run_cycle(br_pc, '0, p, rd);
        check_value("pred_o.next_pc", 64'(p.next_pc), 64'(br_pc + 32'd4));
        csr_write(wb_adr_t'(`BP_CSR_CTRL), 32'h3);
        run_cycle(jmp_pc, '0, p, rd);
        check_value("pred_o.meta.hit", 64'(p.meta.hit), 64'd0);
        check_value("pred_o.meta.ghr", 64'(p.meta.ghr), 64'd0);
        check_value("pred_o.next_pc", 64'(p.next_pc), 64'(jmp_pc + 32'd4));
        csr_read(wb_adr_t'(`BP_CSR_CTRL), rdata);
        check_value("wb_o.dat CTRL", 64'(rdata), 64'd1);
        csr_write(wb_adr_t'(`BP_CSR_BRANCHES), 32'h0);
        csr_read(wb_adr_t'(`BP_CSR_BRANCHES), rdata);
        check_value("wb_o.dat BRANCHES", 64'(rdata), 64'd0);
        csr_read(wb_adr_t'(`BP_CSR_REDIRECTS), rdata);
        check_value("wb_o.dat REDIRECTS", 64'(rdata), 64'd0);

        @(posedge clk);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
hw/bp_pkg.sv
hw/bp_btb.sv
hw/bp_pht.sv
hw/bp_next_pc.sv
hw/bp_csr.sv
hw/bp_top.sv
bench/bp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the branch predictor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module bp_tb -o bp_sim \
    && ./obj_dir/bp_sim | tee /dev/stderr | grep -qx "TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
